// File: spw_rx.f
+incdir+tests
src/spw_rx_pkg.sv
src/spw_rx_bit_capture.sv
src/spw_rx_char_framer.sv
src/spw_rx_char_decoder.sv
src/spw_rx.sv
tests/tb_spw_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SpaceWire receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f spw_rx.f --top-module tb_spw_rx
./obj_dir/Vtb_spw_rx | tee "$LOG"

if grep -q "^All tests passed$" "$LOG"; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi

// File: tests/spw_rx_model.svh
// Data-strobe line model for the SpaceWire receiver testbench
// Included inside tb_spw_rx and uses its line state, queues and counters
// One bit per testbench clock, so a recovered clock period is two bits
// Parity is odd over previous payload, parity bit and flag bit

`ifndef SPW_RX_MODEL_SVH
`define SPW_RX_MODEL_SVH

// Buffer word for a data char or an EOP/EEP marker, flag on top
function automatic spw_flag_data_t expected_word(input logic is_control,
	input spw_ctrl_t ctrl, input spw_byte_t data);
	if (!is_control)
	begin
		return {1'b0, data};   // Data char, flag 0
	end
	return (ctrl == SPW_CTRL_EEP) ? {1'b1, 8'h01} : {1'b1, 8'h00};   // Markers only
endfunction

// ----------------------------------------------------------
// Line encoding
// ----------------------------------------------------------
// Strobe toggles only when the data bit repeats
task automatic drive_bit(input logic b);
	@(posedge clk);
	if (b == line_bit)
	begin
		line_sin = ~line_sin;
	end
	line_bit = b;
	rx_din <= b;
	rx_sin <= line_sin;
endtask

// Parity, flag, then payload LSB first
task automatic frame_char(input logic flag, input spw_byte_t payload, input int n_bits,
	input logic bad_par);
	logic par;
	par = ~(line_par ^ flag) ^ bad_par;   // Makes the count odd unless bad_par
	drive_bit(par);
	drive_bit(flag);
	line_par = 1'b0;
	for (int i = 0; i < n_bits; i++)
	begin
		drive_bit(payload[i]);
		line_par ^= payload[i];   // Feeds the next parity bit
	end
endtask

task automatic send_ctrl(input spw_ctrl_t code);
	frame_char(1'b1, spw_byte_t'(code), 2, 1'b0);
endtask

task automatic send_data(input spw_byte_t b, input logic bad_par);
	if (expect_writes && !bad_par)
	begin
		exp_words.push_back(expected_word(1'b0, SPW_CTRL_FCT, b));
	end
	frame_char(1'b0, b, 8, bad_par);
endtask

// EOP or EEP
task automatic send_marker(input spw_ctrl_t code);
	if (expect_writes)
	begin
		exp_words.push_back(expected_word(1'b1, code, 8'h00));
	end
	send_ctrl(code);
endtask

task automatic send_fct();
	fct_sent++;
	send_ctrl(SPW_CTRL_FCT);
endtask

task automatic send_null();
	send_ctrl(SPW_CTRL_ESC);
	send_ctrl(SPW_CTRL_FCT);
endtask

task automatic send_time_code(input spw_byte_t b);
	exp_times.push_back(TIME_WIDTH'(b));
	send_ctrl(SPW_CTRL_ESC);
	frame_char(1'b0, b, 8, 1'b0);
endtask

// Keeps the line toggling so the last char gets framed
task automatic send_trailer();
	repeat (TRAIL_NULLS) send_null();
endtask

`endif

// File: tests/tb_spw_rx.sv
// Testbench for the SpaceWire receiver top
// The testbench clock is the bit clock, the DUT recovers its own clock
// Expected words and time codes are queued by the line model tasks
// Ports are sampled on falling clock edges, away from line changes

`timescale 1ns/10ps

module tb_spw_rx
	import spw_rx_pkg::*;
;

	localparam int TIME_WIDTH   = 8;
	localparam int RESET_CYCLES = 16;
	localparam int TRAIL_NULLS  = 2;
	localparam int N_NULLS      = 8;
	localparam int N_DATA       = 40;
	localparam int N_MIXED      = 24;   // 21 data, 3 markers
	localparam int N_TIME       = 5;
	localparam int N_FCT        = 6;
	localparam int N_ERR_DATA   = 7;    // 3 good, 1 bad, 3 ignored
	// Bits per phase, NULL 8, data 10, control 4, time code 14
	localparam int TOTAL_BITS = (N_NULLS + 6 * TRAIL_NULLS) * 8
		+ (N_DATA + N_MIXED - 3 + N_ERR_DATA) * 10 + (3 + N_FCT) * 4 + N_TIME * 14;
	localparam int CYCLE_LIMIT = RESET_CYCLES + TOTAL_BITS + 200;

	typedef struct packed {
		logic error;
		logic got_null;
		logic got_nchar;
		logic got_time_code;
	} rx_status_t;

	logic                  clk;
	logic                  rx_din;
	logic                  rx_sin;
	logic                  rx_resetn;
	logic                  rx_error;
	logic                  rx_got_bit;
	logic                  rx_got_null;
	logic                  rx_got_nchar;
	logic                  rx_got_time_code;
	logic                  rx_got_fct;
	spw_flag_data_t        rx_data_flag;
	logic                  rx_buffer_write;
	logic [TIME_WIDTH-1:0] rx_time_out;
	logic                  rx_tick_out;

	// Line model state
	logic line_bit      = 1'b0;
	logic line_sin      = 1'b0;
	logic line_par      = 1'b0;
	logic expect_writes = 1'b1;

	// Expected and observed events
	spw_flag_data_t        exp_words[$];
	spw_flag_data_t        got_words[$];
	logic [TIME_WIDTH-1:0] exp_times[$];
	logic [TIME_WIDTH-1:0] got_times[$];
	int                    fct_sent    = 0;
	int                    fct_pulses  = 0;
	int                    fct_checked = 0;

	// Monitor edge detect and sampled status
	logic       write_q = 1'b0;
	logic       tick_q  = 1'b0;
	logic       fct_q   = 1'b0;
	rx_status_t status  = '0;

	int    mismatches = 0;
	int    event_errs = 0;
	int    timeouts   = 0;
	string test_name  = "reset";

	`include "spw_rx_model.svh"

	spw_rx #(
		.TIME_WIDTH (TIME_WIDTH)
	) uut (
		.rx_din           (rx_din),
		.rx_sin           (rx_sin),
		.rx_resetn        (rx_resetn),
		.rx_error         (rx_error),
		.rx_got_bit       (rx_got_bit),
		.rx_got_null      (rx_got_null),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_got_fct       (rx_got_fct),
		.rx_data_flag     (rx_data_flag),
		.rx_buffer_write  (rx_buffer_write),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns bit period
	end

	// ----------------------------------------------------------
	// Monitor, falling edges
	// ----------------------------------------------------------
	always @(negedge clk)
	begin
		if (rx_buffer_write && !write_q)
		begin
			got_words.push_back(rx_data_flag);
		end
		if (rx_tick_out && !tick_q)
		begin
			got_times.push_back(rx_time_out);
		end
		if (rx_got_fct && !fct_q)
		begin
			fct_pulses++;
		end
		write_q = rx_buffer_write;
		tick_q  = rx_tick_out;
		fct_q   = rx_got_fct;
		status  = {rx_error, rx_got_null, rx_got_nchar, rx_got_time_code};
	end

	// ----------------------------------------------------------
	// Comparing process, rising edges
	// ----------------------------------------------------------
	always @(posedge clk)
	begin : compare_events
		spw_flag_data_t        got_word;
		spw_flag_data_t        exp_word;
		logic [TIME_WIDTH-1:0] got_time;
		logic [TIME_WIDTH-1:0] exp_time;
		if (got_words.size() > 0)
		begin
			got_word = got_words.pop_front();
			if (exp_words.size() == 0)
			begin
				event_errs++;
				$display("unexpected buffer write of %h during %s", got_word, test_name);
			end
			else
			begin
				exp_word = exp_words.pop_front();
				assert (got_word == exp_word) else
				begin
					mismatches++;
					$display("mismatch %s: expected %h, actual %h", test_name, exp_word, got_word);
				end
			end
		end
		if (got_times.size() > 0)
		begin
			got_time = got_times.pop_front();
			if (exp_times.size() == 0)
			begin
				event_errs++;
				$display("unexpected time code tick of %h during %s", got_time, test_name);
			end
			else
			begin
				exp_time = exp_times.pop_front();
				assert (got_time == exp_time) else
				begin
					mismatches++;
					$display("mismatch %s: expected %h, actual %h", test_name, exp_time, got_time);
				end
			end
		end
		if (fct_pulses > fct_checked)
		begin
			fct_checked++;
			if (fct_checked > fct_sent)   // More pulses than FCTs sent
			begin
				event_errs++;
				$display("unexpected FCT pulse during %s", test_name);
			end
		end
	end

	task automatic check_flag(input string name, input logic exp_val, input logic got_val);
		assert (got_val == exp_val) else
		begin
			mismatches++;
			$display("mismatch %s: %s expected %b, actual %b", test_name, name, exp_val, got_val);
		end
	endtask

	// Until every queued event has shown up, bounded by the watchdog
	task automatic wait_drained();
		while (exp_words.size() > 0 || exp_times.size() > 0 || fct_checked < fct_sent)
		begin
			@(posedge clk);
		end
	endtask

	task automatic finish_run(input logic timed_out);
		if (timed_out)
		begin
			timeouts++;
		end
		$display("error counts: %0d mismatches, %0d missing or extra events, %0d timeouts",
			mismatches, event_errs, timeouts);
		if (mismatches + event_errs + timeouts == 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial
	begin : run_tests
		void'($urandom(34));
		rx_din    <= 1'b0;
		rx_sin    <= 1'b0;
		rx_resetn <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rx_resetn <= 1'b1;
		@(negedge clk);
		check_flag("rx_got_bit", 1'b0, rx_got_bit);   // Idle line
		check_flag("rx_buffer_write", 1'b0, rx_buffer_write);

		test_name = "null";
		repeat (N_NULLS) send_null();
		send_trailer();
		wait_drained();
		check_flag("rx_got_null", 1'b1, status.got_null);
		check_flag("rx_got_nchar", 1'b0, status.got_nchar);
		check_flag("rx_error", 1'b0, status.error);

		test_name = "data";
		for (int i = 0; i < N_DATA; i++)
		begin
			send_data(spw_byte_t'($urandom), 1'b0);
		end
		send_trailer();
		wait_drained();
		check_flag("rx_got_nchar", 1'b1, status.got_nchar);
		check_flag("rx_error", 1'b0, status.error);

		test_name = "markers";
		for (int i = 0; i < N_MIXED; i++)
		begin
			if (i == 7 || i == 23)
				send_marker(SPW_CTRL_EOP);
			else if (i == 15)
				send_marker(SPW_CTRL_EEP);
			else
				send_data(spw_byte_t'($urandom), 1'b0);
		end
		send_trailer();
		wait_drained();
		check_flag("rx_error", 1'b0, status.error);

		test_name = "time_code";
		for (int i = 0; i < N_TIME; i++)
		begin
			send_time_code(spw_byte_t'($urandom));
		end
		send_trailer();
		wait_drained();
		check_flag("rx_got_time_code", 1'b1, status.got_time_code);
		check_flag("rx_error", 1'b0, status.error);

		test_name = "fct";
		repeat (N_FCT) send_fct();
		send_trailer();
		wait_drained();
		check_flag("rx_error", 1'b0, status.error);

		// Decoder halts on the bad char, nothing after it is written
		test_name = "parity_error";
		repeat (3) send_data(spw_byte_t'($urandom), 1'b0);
		expect_writes = 1'b0;
		send_data(spw_byte_t'($urandom), 1'b1);
		repeat (N_ERR_DATA - 4) send_data(spw_byte_t'($urandom), 1'b0);
		send_trailer();
		wait_drained();
		@(posedge clk);   // Last monitor sample reaches the compare
		check_flag("rx_error", 1'b1, status.error);
		check_flag("rx_got_null", 1'b1, status.got_null);
		finish_run(1'b0);
	end

	// Watchdog on total line bits
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles in %s, %0d writes, %0d ticks, %0d FCTs missing",
			cycles, test_name, exp_words.size(), exp_times.size(), fct_sent - fct_checked);
		finish_run(1'b1);
	end

endmodule

// File: src/spw_rx.sv
// SpaceWire receiver top, data-strobe decoding down to character events
// Clock is recovered from the line, so no free running clock is needed
// Logic only advances while the line toggles, so the last character
// is reported only after some trailing bits such as NULLs
// Both rx_din and rx_sin must be low while rx_resetn is asserted
// Event latency is three to four bit periods after the last bit

`timescale 1ns/10ps

module spw_rx
	import spw_rx_pkg::*;
#(
	parameter int TIME_WIDTH = 8   // Width of the time-code output
)
(
	input  logic                  rx_din,
	input  logic                  rx_sin,
	input  logic                  rx_resetn,
	output logic                  rx_error,
	output logic                  rx_got_bit,
	output logic                  rx_got_null,
	output logic                  rx_got_nchar,
	output logic                  rx_got_time_code,
	output logic                  rx_got_fct,
	output spw_flag_data_t        rx_data_flag,
	output logic                  rx_buffer_write,
	output logic [TIME_WIDTH-1:0] rx_time_out,
	output logic                  rx_tick_out
);

	logic       posedge_clk;   // Rises on even bits
	logic       negedge_clk;   // Rises on odd bits
	logic       f_time;        // First even edge seen
	logic [1:0] bit_pair;
	spw_char_t  char_word;
	logic       char_valid;

	// ----------------------------------------------------------
	// Clock recovery
	// ----------------------------------------------------------
	assign posedge_clk = rx_din ^ rx_sin;

	// Kept low before the first bit, else the idle low line would
	// give a rising negedge_clk out of reset
	assign negedge_clk = f_time ? ~posedge_clk : 1'b0;

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			f_time <= 1'b0;
		end
		else
		begin
			f_time <= 1'b1;
		end
	end

	assign rx_got_bit = rx_din | rx_sin;   // Any activity on the pair

	// ----------------------------------------------------------
	// Receive chain
	// ----------------------------------------------------------
	spw_rx_bit_capture u_bit_capture (
		.posedge_clk (posedge_clk),
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.bit_pair    (bit_pair)
	);

	spw_rx_char_framer u_char_framer (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_pair    (bit_pair),
		.char_out    (char_word),
		.char_valid  (char_valid)
	);

	spw_rx_char_decoder #(
		.TIME_WIDTH (TIME_WIDTH)
	) u_char_decoder (
		.posedge_clk      (posedge_clk),
		.rx_resetn        (rx_resetn),
		.char_in          (char_word),
		.char_valid       (char_valid),
		.rx_error         (rx_error),
		.rx_got_null      (rx_got_null),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_got_fct       (rx_got_fct),
		.rx_data_flag     (rx_data_flag),
		.rx_buffer_write  (rx_buffer_write),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out)
	);

endmodule

// File: src/spw_rx_char_decoder.sv
// Escape decoder and event generation for framed characters
// All outputs are registered one posedge_clk after char_valid
// got_null, got_nchar, got_time_code and rx_error are sticky until reset
// After any error the decoder ignores the line until reset
// Time code is truncated or zero-extended to TIME_WIDTH

`timescale 1ns/10ps

module spw_rx_char_decoder
	import spw_rx_pkg::*;
#(
	parameter int TIME_WIDTH = 8
)
(
	input  logic                  posedge_clk,
	input  logic                  rx_resetn,
	input  spw_char_t             char_in,
	input  logic                  char_valid,
	output logic                  rx_error,
	output logic                  rx_got_null,
	output logic                  rx_got_nchar,
	output logic                  rx_got_time_code,
	output logic                  rx_got_fct,
	output spw_flag_data_t        rx_data_flag,
	output logic                  rx_buffer_write,
	output logic [TIME_WIDTH-1:0] rx_time_out,
	output logic                  rx_tick_out
);

	spw_dec_state_e state;
	logic           char_bad;   // Parity failure on a live char

	assign char_bad = char_valid && !char_in.parity_ok && (state != DEC_HALTED);

	// ----------------------------------------------------------
	// Escape FSM with output registers
	// ----------------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state            <= DEC_IDLE;
			rx_error         <= 1'b0;
			rx_got_null      <= 1'b0;
			rx_got_nchar     <= 1'b0;
			rx_got_time_code <= 1'b0;
			rx_got_fct       <= 1'b0;
			rx_data_flag     <= '0;
			rx_buffer_write  <= 1'b0;
			rx_time_out      <= '0;
			rx_tick_out      <= 1'b0;
		end
		else
		begin
			// Pulses default low
			rx_got_fct      <= 1'b0;
			rx_buffer_write <= 1'b0;
			rx_tick_out     <= 1'b0;

			if (char_bad)
			begin
				rx_error <= 1'b1;
				state    <= DEC_HALTED;
			end
			else if (char_valid)
			begin
				case (state)
					DEC_IDLE:
					begin
						if (!char_in.is_control)
						begin
							// Plain data char goes to the buffer
							rx_data_flag    <= {1'b0, char_in.data};
							rx_buffer_write <= 1'b1;
							rx_got_nchar    <= 1'b1;
						end
						else
						begin
							case (char_in.ctrl)
								SPW_CTRL_FCT: rx_got_fct <= 1'b1;
								SPW_CTRL_EOP:
								begin
									rx_data_flag    <= EOP_WORD;
									rx_buffer_write <= 1'b1;
								end
								SPW_CTRL_EEP:
								begin
									rx_data_flag    <= EEP_WORD;
									rx_buffer_write <= 1'b1;
								end
								default: state <= DEC_AFTER_ESC;   // ESC
							endcase
						end
					end

					DEC_AFTER_ESC:
					begin
						if (!char_in.is_control)
						begin
							// ESC + data is a time code
							rx_time_out      <= TIME_WIDTH'(char_in.data);
							rx_tick_out      <= 1'b1;
							rx_got_time_code <= 1'b1;
							state            <= DEC_IDLE;
						end
						else if (char_in.ctrl == SPW_CTRL_FCT)
						begin
							rx_got_null <= 1'b1;   // ESC + FCT
							state       <= DEC_IDLE;
						end
						else
						begin
							// ESC followed by ESC, EOP or EEP
							rx_error <= 1'b1;
							state    <= DEC_HALTED;
						end
					end

					default:
					begin
						state <= DEC_HALTED;   // Only reset leaves
					end
				endcase
			end
		end
	end

endmodule

// File: src/spw_rx_char_framer.sv
// Character framer working on bit pairs in the posedge_clk domain
// Every character starts on an even bit, so parity and flag share one pair
// The very first pair after reset holds reset values and is skipped
// A character is only emitted once the line toggles on past its last bit
// Parity state starts at zero after reset

`timescale 1ns/10ps

module spw_rx_char_framer
	import spw_rx_pkg::*;
(
	input  logic       posedge_clk,
	input  logic       rx_resetn,
	input  logic [1:0] bit_pair,
	output spw_char_t  char_out,
	output logic       char_valid
);

	logic       primed;        // Set after the stale first pair
	logic [2:0] pairs_left;    // Payload pairs still to come, 0 = header next
	logic       flag_q;        // Flag of the char in progress
	logic       parity_ok_q;   // Parity result taken at the header
	logic       prev_par;      // XOR of the previous char's payload
	spw_byte_t  shift_q;       // Data bits, shifted in from the top
	spw_byte_t  data_next;     // Shift register after this pair
	spw_ctrl_t  ctrl_next;     // Control code if this pair is the payload
	spw_byte_t  marker_byte;   // Byte stored for EOP/EEP
	logic       header_par;    // Odd parity check at the header
	logic       last_pair;     // This pair completes the char

	// ----------------------------------------------------------
	// Pair decoding
	// ----------------------------------------------------------
	// bit_pair[1] is the older bit, so it sits below bit_pair[0]
	assign data_next  = {bit_pair[0], bit_pair[1], shift_q[7:2]};
	assign ctrl_next  = {bit_pair[0], bit_pair[1]};   // c0 first on the line
	assign header_par = prev_par ^ bit_pair[1] ^ bit_pair[0];   // 1 when odd
	assign last_pair  = (pairs_left == 3'd1);

	always_comb
	begin
		case (ctrl_next)
			SPW_CTRL_EOP: marker_byte = EOP_WORD[7:0];
			SPW_CTRL_EEP: marker_byte = EEP_WORD[7:0];
			default:      marker_byte = '0;   // FCT and ESC carry no byte
		endcase
	end

	// ----------------------------------------------------------
	// Framing control
	// ----------------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			primed      <= 1'b0;
			pairs_left  <= '0;
			flag_q      <= 1'b0;
			parity_ok_q <= 1'b0;
			prev_par    <= 1'b0;
			char_valid  <= 1'b0;
		end
		else
		begin
			char_valid <= 1'b0;   // One cycle strobe

			if (!primed)
			begin
				primed <= 1'b1;   // Pair still holds reset values
			end
			else if (pairs_left == 3'd0)
			begin
				// Header pair, parity then flag
				flag_q      <= bit_pair[0];
				parity_ok_q <= header_par;
				pairs_left  <= bit_pair[0] ? SPW_CTRL_PAIRS : SPW_DATA_PAIRS;
			end
			else
			begin
				pairs_left <= pairs_left - 3'd1;
				if (last_pair)
				begin
					char_valid <= 1'b1;
					// Payload parity feeds the next header check
					prev_par   <= flag_q ? ^ctrl_next : ^data_next;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Payload path
	// ----------------------------------------------------------
	always_ff @(posedge posedge_clk)
	begin
		if (pairs_left != 3'd0)
		begin
			shift_q <= data_next;   // Control pairs pass through too, harmless
		end

		if (last_pair)
		begin
			char_out.is_control <= flag_q;
			char_out.ctrl       <= flag_q ? ctrl_next : SPW_CTRL_FCT;
			char_out.data       <= flag_q ? marker_byte : data_next;
			char_out.parity_ok  <= parity_ok_q;
		end
	end

endmodule

// File: src/spw_rx_bit_capture.sv
// Dual-edge bit capture for the recovered data-strobe clock
// Even bits land on posedge_clk, odd bits on negedge_clk
// Assumes the first bit after reset arrives on a rising recovered edge
// The pair output is only valid when sampled on posedge_clk

`timescale 1ns/10ps

module spw_rx_bit_capture
(
	input  logic       posedge_clk,
	input  logic       negedge_clk,
	input  logic       rx_resetn,
	input  logic       rx_din,
	output logic [1:0] bit_pair
);

	logic pos_bit;   // Last even bit
	logic neg_bit;   // Last odd bit

	// ----------------------------------------------------------
	// Even bits
	// ----------------------------------------------------------
	// The rising recovered edge is caused by this very bit arriving,
	// so rx_din already holds the new bit here
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			pos_bit <= 1'b0;
		end
		else
		begin
			pos_bit <= rx_din;   // Bit 2k
		end
	end

	// ----------------------------------------------------------
	// Odd bits
	// ----------------------------------------------------------
	// negedge_clk stays low until the first even bit, so no
	// spurious capture right after reset
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			neg_bit <= 1'b0;
		end
		else
		begin
			neg_bit <= rx_din;   // Bit 2k+1
		end
	end

	// Pair in line order, older bit on top
	// Between the odd edge and the next even edge both registers
	// hold bits 2k and 2k+1, which is what posedge_clk samples downstream
	// Half-period path from the negedge_clk domain
	assign bit_pair = {pos_bit, neg_bit};

endmodule

// File: src/spw_rx_pkg.sv
// Shared types for the SpaceWire receive path
// Control codes follow the two-bit line encoding, sent least significant bit first
// EOP and EEP are stored in the receive buffer as flag 1 over a marker byte
// The decoder states are shared so that other blocks can observe the state

package spw_rx_pkg;

	// ----------------------------------------------------------
	// Plain vector types
	// ----------------------------------------------------------
	typedef logic [7:0] spw_byte_t;        // Data byte or time-code byte
	typedef logic [1:0] spw_ctrl_t;        // Two control bits of a control char
	typedef logic [8:0] spw_flag_data_t;   // Buffer word with the flag on top

	// Control codes as seen on the line
	localparam spw_ctrl_t SPW_CTRL_FCT = 2'd0;
	localparam spw_ctrl_t SPW_CTRL_EOP = 2'd1;
	localparam spw_ctrl_t SPW_CTRL_EEP = 2'd2;
	localparam spw_ctrl_t SPW_CTRL_ESC = 2'd3;

	// Buffer words for the packet markers
	localparam spw_flag_data_t EOP_WORD = 9'h100;   // Normal end of packet
	localparam spw_flag_data_t EEP_WORD = 9'h101;   // Error end of packet

	// Payload length in bit pairs after the parity/flag pair
	localparam logic [2:0] SPW_CTRL_PAIRS = 3'd1;   // Two control bits
	localparam logic [2:0] SPW_DATA_PAIRS = 3'd4;   // Eight data bits

	// ----------------------------------------------------------
	// One framed character
	// ----------------------------------------------------------
	// ctrl is only meaningful for control chars
	// For a control char data carries the marker byte of EOP/EEP, else zero
	typedef struct packed {
		logic      is_control;   // Flag bit from the line
		spw_ctrl_t ctrl;         // Control code
		spw_byte_t data;         // Data byte, LSB received first
		logic      parity_ok;    // Odd parity over prev payload + parity + flag
	} spw_char_t;

	// ----------------------------------------------------------
	// Escape decoder states
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		DEC_IDLE,        // Normal character stream
		DEC_AFTER_ESC,   // ESC seen, next char completes NULL or time code
		DEC_HALTED       // Error seen, stays here until reset
	} spw_dec_state_e;

endpackage
